// File: core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// RV32 word, also the address width.
`define CORE_XLEN 32

// Register file geometry.
`define CORE_REG_AW 5
`define CORE_REG_COUNT 32

// First fetch address once rst is released.
`define CORE_RESET_VECTOR 32'h0000_0800

// Sequential step of the PC and link offset of JAL and JALR.
`define CORE_INSTR_BYTES 32'd4

`endif

// File: corePkg.sv
package corePkg;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } aluOpT;

    typedef enum logic [1:0] {
        PC_SEQ,    // PC plus 4.
        PC_BRANCH, // PC plus immediate when the condition holds.
        PC_JUMP    // ALU result with bit 0 cleared.
    } pcSrcT;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK,
        WB_IMM
    } wbSrcT;

    // Encoded as the funct3 field of the branch.
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branchCondT;

endpackage

// File: pcUnit.sv
`timescale 1ns/100ps
`include "core_config.svh"

module pcUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  corePkg::pcSrcT         pcSrc,
    input  corePkg::branchCondT    branchCond,
    input  logic [`CORE_XLEN-1:0]  rs1Data,
    input  logic [`CORE_XLEN-1:0]  rs2Data,
    input  logic [`CORE_XLEN-1:0]  imm,
    input  logic [`CORE_XLEN-1:0]  jumpTarget,
    output logic [`CORE_XLEN-1:0]  pc,
    output logic [`CORE_XLEN-1:0]  pcPlus4
);

    logic [`CORE_XLEN-1:0] nextPc;
    logic                  isEqual;
    logic                  isLess;
    logic                  isLessU;
    logic                  takeBranch;

    assign isEqual = rs1Data == rs2Data;
    assign isLess  = $signed(rs1Data) < $signed(rs2Data);
    assign isLessU = rs1Data < rs2Data;

    always_comb begin
        case (branchCond)
            corePkg::BR_EQ:  takeBranch = isEqual;
            corePkg::BR_NE:  takeBranch = !isEqual;
            corePkg::BR_LT:  takeBranch = isLess;
            corePkg::BR_GE:  takeBranch = !isLess;
            corePkg::BR_LTU: takeBranch = isLessU;
            corePkg::BR_GEU: takeBranch = !isLessU;
            default:         takeBranch = 1'b0;
        endcase
    end

    always_comb begin
        case (pcSrc)
            corePkg::PC_BRANCH: nextPc = takeBranch ? pc + imm : pcPlus4;
            corePkg::PC_JUMP:   nextPc = {jumpTarget[`CORE_XLEN-1:1], 1'b0};
            default:            nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CORE_RESET_VECTOR;
        end else begin
            pc <= nextPc;
        end
    end

    assign pcPlus4 = pc + `CORE_INSTR_BYTES;

    // A misaligned branch offset or JALR target shows up here.
    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

// File: regFile.sv
`timescale 1ns/100ps
`include "core_config.svh"

module regFile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    writeEn,
    input  logic [`CORE_REG_AW-1:0] writeAddr,
    input  logic [`CORE_REG_AW-1:0] readAddrA,
    input  logic [`CORE_REG_AW-1:0] readAddrB,
    input  logic [`CORE_XLEN-1:0]   writeData,
    output logic [`CORE_XLEN-1:0]   readDataA,
    output logic [`CORE_XLEN-1:0]   readDataB
);

    // x0 has no storage.
    logic [`CORE_XLEN-1:0] regs [1:`CORE_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// File: instrDecoder.sv
`timescale 1ns/100ps
`include "core_config.svh"

module instrDecoder (
    input  logic [31:0]              instr,
    output logic [`CORE_REG_AW-1:0]  rs1Addr,
    output logic [`CORE_REG_AW-1:0]  rs2Addr,
    output logic [`CORE_REG_AW-1:0]  rdAddr,
    output logic [`CORE_XLEN-1:0]    imm,
    output corePkg::aluOpT           aluOp,
    output logic                     aluSrcPc,
    output logic                     aluSrcImm,
    output corePkg::pcSrcT           pcSrc,
    output corePkg::branchCondT      branchCond,
    output corePkg::wbSrcT           wbSrc,
    output logic                     regWrite,
    output logic                     memRead,
    output logic                     memWrite
);

    corePkg::opcodeT       opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`CORE_XLEN-1:0] immI;
    logic [`CORE_XLEN-1:0] immS;
    logic [`CORE_XLEN-1:0] immB;
    logic [`CORE_XLEN-1:0] immU;
    logic [`CORE_XLEN-1:0] immJ;
    logic                  isImm;
    logic                  altFn;
    logic                  immNoF7;
    logic                  altAllowed;
    logic                  arithValid;
    corePkg::aluOpT        arithOp;

    assign opcode  = corePkg::opcodeT'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rdAddr  = instr[11:7];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // OP and OP_IMM share one funct3 map.
    assign isImm      = opcode == corePkg::OPC_OP_IMM;
    assign altFn      = funct7 == 7'b0100000;
    assign immNoF7    = isImm && funct3 != 3'b001 && funct3 != 3'b101; // Upper bits are imm.
    assign altAllowed = funct3 == 3'b101 || (funct3 == 3'b000 && !isImm);
    assign arithValid = immNoF7 || funct7 == 7'b0 || (altFn && altAllowed);

    always_comb begin
        case (funct3)
            3'b000:  arithOp = (altFn && !isImm) ? corePkg::ALU_SUB : corePkg::ALU_ADD;
            3'b001:  arithOp = corePkg::ALU_SLL;
            3'b010:  arithOp = corePkg::ALU_SLT;
            3'b011:  arithOp = corePkg::ALU_SLTU;
            3'b100:  arithOp = corePkg::ALU_XOR;
            3'b101:  arithOp = altFn ? corePkg::ALU_SRA : corePkg::ALU_SRL;
            3'b110:  arithOp = corePkg::ALU_OR;
            default: arithOp = corePkg::ALU_AND;
        endcase
    end

    always_comb begin
        aluOp      = corePkg::ALU_ADD;
        aluSrcPc   = 1'b0;
        aluSrcImm  = 1'b0;
        pcSrc      = corePkg::PC_SEQ;
        branchCond = corePkg::BR_EQ;
        wbSrc      = corePkg::WB_ALU;
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        imm        = immI;
        case (opcode)
            corePkg::OPC_OP: begin
                aluOp    = arithOp;
                regWrite = arithValid;
            end
            corePkg::OPC_OP_IMM: begin
                aluOp     = arithOp;
                aluSrcImm = 1'b1;
                regWrite  = arithValid;
            end
            corePkg::OPC_LOAD: begin
                aluSrcImm = 1'b1;
                wbSrc     = corePkg::WB_MEM;
                memRead   = funct3 == 3'b010; // LW only.
                regWrite  = funct3 == 3'b010;
            end
            corePkg::OPC_STORE: begin
                imm       = immS;
                aluSrcImm = 1'b1;
                memWrite  = funct3 == 3'b010; // SW only.
            end
            corePkg::OPC_BRANCH: begin
                imm = immB;
                if (funct3[2:1] != 2'b01) begin
                    pcSrc      = corePkg::PC_BRANCH;
                    branchCond = corePkg::branchCondT'(funct3);
                end
            end
            corePkg::OPC_JAL: begin
                imm       = immJ;
                aluSrcPc  = 1'b1;
                aluSrcImm = 1'b1;
                pcSrc     = corePkg::PC_JUMP;
                wbSrc     = corePkg::WB_LINK;
                regWrite  = 1'b1;
            end
            corePkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    aluSrcImm = 1'b1;
                    pcSrc     = corePkg::PC_JUMP;
                    wbSrc     = corePkg::WB_LINK;
                    regWrite  = 1'b1;
                end
            end
            corePkg::OPC_LUI: begin
                imm      = immU;
                wbSrc    = corePkg::WB_IMM;
                regWrite = 1'b1;
            end
            corePkg::OPC_AUIPC: begin
                imm       = immU;
                aluSrcPc  = 1'b1;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            default: ; // Unknown opcode falls through as a no-op.
        endcase
    end

endmodule

// File: aluUnit.sv
`timescale 1ns/100ps
`include "core_config.svh"

module aluUnit (
    input  corePkg::aluOpT         aluOp,
    input  logic [`CORE_XLEN-1:0]  opA,
    input  logic [`CORE_XLEN-1:0]  opB,
    output logic [`CORE_XLEN-1:0]  result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = opB[4:0];
    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    always_comb begin
        case (aluOp)
            corePkg::ALU_ADD:  result = opA + opB;
            corePkg::ALU_SUB:  result = opA - opB;
            corePkg::ALU_SLL:  result = opA << shamt;
            corePkg::ALU_SRL:  result = opA >> shamt;
            corePkg::ALU_SRA:  result = $signed(opA) >>> shamt; // Sign fills from the top.
            corePkg::ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, lessSigned};
            corePkg::ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, lessUnsigned};
            corePkg::ALU_AND:  result = opA & opB;
            corePkg::ALU_OR:   result = opA | opB;
            corePkg::ALU_XOR:  result = opA ^ opB;
            default:           result = '0;
        endcase
    end

endmodule

// File: singleCycleCore.sv
`timescale 1ns/100ps
`include "core_config.svh"

module singleCycleCore (
    input  logic                  clk,
    input  logic                  rst,
    output logic [`CORE_XLEN-1:0] instrAddr,
    input  logic [31:0]           instr,
    output logic                  memRead,
    output logic                  memWrite,
    output logic [`CORE_XLEN-1:0] dataAddr,
    output logic [`CORE_XLEN-1:0] dataOut,
    input  logic [`CORE_XLEN-1:0] dataIn
);

    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_XLEN-1:0]   pcPlus4;
    logic [`CORE_XLEN-1:0]   rs1Data;
    logic [`CORE_XLEN-1:0]   rs2Data;
    logic [`CORE_XLEN-1:0]   imm;
    logic [`CORE_XLEN-1:0]   opA;
    logic [`CORE_XLEN-1:0]   opB;
    logic [`CORE_XLEN-1:0]   aluResult;
    logic [`CORE_XLEN-1:0]   wbData;
    logic [`CORE_REG_AW-1:0] rs1Addr;
    logic [`CORE_REG_AW-1:0] rs2Addr;
    logic [`CORE_REG_AW-1:0] rdAddr;
    corePkg::aluOpT          aluOp;
    corePkg::pcSrcT          pcSrc;
    corePkg::branchCondT     branchCond;
    corePkg::wbSrcT          wbSrc;
    logic                    aluSrcPc;
    logic                    aluSrcImm;
    logic                    decRegWrite;
    logic                    decMemRead;
    logic                    decMemWrite;
    logic                    regWriteEn;

    instrDecoder u_decoder (
        .instr(instr), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .imm(imm), .aluOp(aluOp), .aluSrcPc(aluSrcPc), .aluSrcImm(aluSrcImm),
        .pcSrc(pcSrc), .branchCond(branchCond), .wbSrc(wbSrc),
        .regWrite(decRegWrite), .memRead(decMemRead), .memWrite(decMemWrite)
    );

    regFile u_regFile (
        .clk(clk), .rst(rst), .writeEn(regWriteEn), .writeAddr(rdAddr),
        .readAddrA(rs1Addr), .readAddrB(rs2Addr), .writeData(wbData),
        .readDataA(rs1Data), .readDataB(rs2Data)
    );

    assign opA = aluSrcPc ? pc : rs1Data;
    assign opB = aluSrcImm ? imm : rs2Data;

    aluUnit u_alu (.aluOp(aluOp), .opA(opA), .opB(opB), .result(aluResult));

    pcUnit u_pc (
        .clk(clk), .rst(rst), .pcSrc(pcSrc), .branchCond(branchCond),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .jumpTarget(aluResult),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    always_comb begin
        case (wbSrc)
            corePkg::WB_MEM:  wbData = dataIn;
            corePkg::WB_LINK: wbData = pcPlus4;
            corePkg::WB_IMM:  wbData = imm;
            default:          wbData = aluResult;
        endcase
    end

    // No architectural side effects while in reset.
    assign regWriteEn = decRegWrite && !rst;
    assign memRead    = decMemRead && !rst;
    assign memWrite   = decMemWrite && !rst;

    assign instrAddr = pc;
    assign dataAddr  = aluResult; // Base plus offset.
    assign dataOut   = rs2Data;

    // Only word accesses exist.
    dataAligned: assert property (@(posedge clk) disable iff (rst)
        (memRead || memWrite) |-> dataAddr[1:0] == 2'b00)
        else $error("misaligned data access at %h", dataAddr);

endmodule

// File: tbClock.sv
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0; // Released just after the fourth edge.
    end

    always #10 clk = ~clk;

endmodule

// File: tbCore.sv
`timescale 1ns/100ps
`include "core_config.svh"

module tbCore;

    localparam logic [31:0] endMarker = 32'hFFFF_FFFF;
    localparam logic [31:0] haltInstr = 32'h0000_006F; // jal x0, 0

    logic                  clk;
    logic                  rst;
    logic [`CORE_XLEN-1:0] instrAddr;
    logic [31:0]           instr;
    logic                  memRead;
    logic                  memWrite;
    logic [`CORE_XLEN-1:0] dataAddr;
    logic [`CORE_XLEN-1:0] dataOut;
    logic [`CORE_XLEN-1:0] dataIn;

    logic [31:0] testData [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] fetchIdx;
    logic [31:0] progLen;
    logic [31:0] haltAddr;
    logic [31:0] expAddrQ [$];
    logic [31:0] expDataQ [$];
    int          storesSeen;
    int          mismatches;
    int          otherErrors;
    int          cycles;
    int          cycleLimit;

    tbClock u_clock (.clk(clk), .rst(rst));

    singleCycleCore u_dut (
        .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
        .memRead(memRead), .memWrite(memWrite), .dataAddr(dataAddr),
        .dataOut(dataOut), .dataIn(dataIn)
    );

    // Program image sits at the reset vector. Anything outside it reads as a NOP.
    assign fetchIdx = (instrAddr - `CORE_RESET_VECTOR) >> 2;
    assign instr    = (instrAddr >= `CORE_RESET_VECTOR && fetchIdx < progLen) ?
                      testData[fetchIdx[7:0]] : 32'h0000_0013;

    // Data only comes back on a read strobe.
    assign dataIn = memRead ? dmem[dataAddr[9:2]] : '0;

    always @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a[7:0]] <= 32'hA5A5_0000 ^ (32'(a) << 2);
            end
        end else if (memWrite) begin
            dmem[dataAddr[9:2]] <= dataOut;
        end
    end

    task automatic finishRun();
        $display("stores checked %0d, mismatches %0d, other errors %0d",
                 storesSeen, mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic checkStore();
        logic [31:0] expAddr;
        logic [31:0] expData;
        if (expAddrQ.size() == 0) begin
            otherErrors++;
            $display("more stores than expected, extra store to %h", dataAddr);
        end else begin
            expAddr = expAddrQ.pop_front();
            expData = expDataQ.pop_front();
            if (dataAddr !== expAddr) begin
                mismatches++;
                $display("mismatch dataAddr store %0d: got %h expected %h",
                         storesSeen, dataAddr, expAddr);
            end
            if (dataOut !== expData) begin
                mismatches++;
                $display("mismatch dataOut store %0d: got %h expected %h",
                         storesSeen, dataOut, expData);
            end
            storesSeen++;
        end
    endtask

    task automatic checkHalt();
        if (instrAddr !== haltAddr) begin
            mismatches++;
            $display("mismatch instrAddr at halt: got %h expected %h", instrAddr, haltAddr);
        end
        if (expAddrQ.size() != 0) begin
            otherErrors++;
            $display("halted with %0d expected stores still missing", expAddrQ.size());
        end
    endtask

    initial begin
        int          i;
        logic [7:0]  j;
        logic [31:0] count;
        storesSeen  = 0;
        mismatches  = 0;
        otherErrors = 0;
        cycles      = 0;
        progLen     = '0;
        haltAddr    = '0;
        cycleLimit  = 50;
        $readmemh("core_testdata.hex", testData);
        i = 0;
        while (i < 255 && testData[i[7:0]] !== endMarker) begin
            i++;
        end
        if (testData[i[7:0]] !== endMarker) begin
            otherErrors++;
            $display("test data has no end marker after the program");
            finishRun();
        end else begin
            progLen = 32'(i);
            j       = i[7:0] + 8'd1;
            count   = testData[j];
            j       = j + 8'd1;
            for (int k = 0; k < int'(count); k++) begin
                expAddrQ.push_back(testData[j]);
                expDataQ.push_back(testData[j + 8'd1]);
                j = j + 8'd2;
            end
            haltAddr   = testData[j];
            cycleLimit = 4 * i + 50;
        end
    end

    // Outputs are settled by the falling edge.
    always @(negedge clk) begin
        if (rst) begin
            if (memWrite !== 1'b0) begin
                otherErrors++;
                $display("memWrite was high while rst was asserted");
            end
        end else begin
            if (cycles == 0 && instrAddr !== `CORE_RESET_VECTOR) begin
                mismatches++;
                $display("mismatch instrAddr first fetch: got %h expected %h",
                         instrAddr, `CORE_RESET_VECTOR);
            end
            cycles++;
            if ((memRead || memWrite) && dataAddr[31:10] != '0) begin
                otherErrors++;
                $display("data access outside the data memory at %h", dataAddr);
            end
            if (memWrite) begin
                checkStore();
            end
            if (instr === haltInstr) begin
                checkHalt();
                finishRun();
            end else if (cycles > cycleLimit) begin
                otherErrors++;
                $display("timeout before halt after %0d cycles", cycles);
                finishRun();
            end
        end
    end

endmodule

// File: core_testdata.hex
// Program words from 0x800 come first, four to a line.
// After FFFFFFFF come the store count, the address and data of each store, and the halt address.
FF900093 00500113 002081B3 00302023
40110233 00402223 002112B3 00502423
0020D333 00602623 4020D3B3 00702823
0020A433 00802A23 0020B4B3 00902C23
0040F533 00A02E23 004165B3 02B02023
0040C633 02C02223
// I-type operations, each stored.
06408693 02D02423 FFA0A713 02E02623
0030B793 02F02823 0F00F813 03002A23
F0016893 03102C23 FFF0C913 03202E23
01C11993 05302023 0040DD13 05A02223
4048DD93 05B02423
// Store, load back, add one and store again.
05102623 04C02E03 001E0E13 05C02823
// Each branch taken and then not taken. Only the not taken ones add to x20.
00210463 040A0A13 00208463 001A0A13
00209463 080A0A13 00211463 002A0A13
0020C463 100A0A13 00114463 004A0A13
00115463 200A0A13 0020D463 008A0A13
00116463 400A0A13 0020E463 010A0A13
0020F463 800A0A13 00117463 020A0A13
05402A23
// Upper immediates, jumps with links and the halt loop.
12345AB7 05502C23 00001B17 05602E23
00800BEF 06002023 07702023 011B8C67
06002223 07802223 0000006F
FFFFFFFF
0000001A
00000000 FFFFFFFE 00000004 0000000C
00000008 000000A0 0000000C 07FFFFFF
00000010 FFFFFFFF 00000014 00000001
00000018 00000000 0000001C 00000008
00000020 0000000D 00000024 FFFFFFF5
00000028 0000005D 0000002C 00000001
00000030 00000000 00000034 000000F0
00000038 FFFFFF05 0000003C 00000006
00000040 50000000 00000044 0FFFFFFF
00000048 FFFFFFF0 0000004C FFFFFF05
00000050 FFFFFF06 00000054 0000003F
00000058 12345000 0000005C 0000191C
00000060 00000928 00000064 00000934
0000093C

// File: tb.f
+incdir+.
corePkg.sv
pcUnit.sv
regFile.sv
instrDecoder.sv
aluUnit.sv
singleCycleCore.sv
tbClock.sv
tbCore.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbCore
FILELIST = tb.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
